// ==== build.f ====
common/dmem_geom_pkg.sv
common/dmem_access_pkg.sv
dmem_bank/dmem_bank.sv
design/dmem_controller.sv
design/lane_steer.sv
design/load_align.sv
design/dmem_top.sv
sim/dmem_checker.sv
sim/dmem_tb.sv

// ==== Makefile ====
SIM       = verilator
SIM_FLAGS = --binary --timing --timescale 1ns/1ps
TOP       = dmem_tb
FILELIST  = build.f

OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "TESTBENCH FAILED" $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/dmem_tb.sv ====
`timescale 1ns/1ps

module dmem_tb;
    import dmem_geom_pkg::*;
    import dmem_access_pkg::*;

    localparam int ADDR_W  = 15;
    localparam int NUM_REQ = 2000;
    localparam int TIMEOUT = 50;        // Cycles allowed for any one wait

    logic              clk;
    logic              reset;
    logic              req_valid;
    logic              req_ready;
    mem_op_e           req_op;
    access_size_e      req_size;
    logic              req_unsigned;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_wdata;
    logic              resp_valid;
    logic              resp_ready;
    logic [DATA_W-1:0] resp_rdata;
    logic              resp_error;
    integer            seed = 32'hca29;
    int                timeouts = 0;
    logic              hung = 1'b0;     // Driver gave up on req_ready
    int                error_count;
    int                req_count;
    int                resp_count;
    int                pending;

    dmem_top #(
        .ADDR_W (ADDR_W)
    ) dmem_top_i (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_op       (req_op),
        .req_size     (req_size),
        .req_unsigned (req_unsigned),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_rdata   (resp_rdata),
        .resp_error   (resp_error)
    );

    dmem_checker #(
        .ADDR_W (ADDR_W)
    ) dmem_checker_i (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .req_op       (req_op),
        .req_size     (req_size),
        .req_unsigned (req_unsigned),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_rdata   (resp_rdata),
        .resp_error   (resp_error),
        .error_count  (error_count),
        .req_count    (req_count),
        .resp_count   (resp_count),
        .pending      (pending)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;          // 4 ns period
    end

    // Advance to the next falling edge and redraw back-pressure
    task automatic next_cycle();
        logic [31:0] rnd;
        @(negedge clk);
        rnd        = $random(seed);
        resp_ready = (rnd[1:0] != 2'b00);   // Ready about 3 cycles in 4
    endtask

    // Random request inside a 64-byte window
    task automatic pick_request();
        logic [31:0] rnd;
        logic [5:0]  offset;
        rnd          = $random(seed);
        offset       = rnd[5:0];
        req_op       = rnd[6] ? OP_STORE : OP_LOAD;
        req_unsigned = rnd[7];
        req_wdata    = $random(seed);
        if (rnd[31:25] < 7'd13) begin           // About 10% refused
            case (rnd[9:8])
                2'd0: begin
                    req_size = access_size_e'(2'd3);
                end
                2'd1: begin
                    req_size  = SIZE_HALF;
                    offset[0] = 1'b1;           // Odd halfword
                end
                default: begin
                    req_size    = SIZE_WORD;
                    offset[1:0] = (offset[1:0] == 2'd0) ? 2'd3 : offset[1:0];
                end
            endcase
        end else begin
            case (rnd[9:8])
                2'd0: begin
                    req_size = SIZE_BYTE;
                end
                2'd1: begin
                    req_size  = SIZE_HALF;
                    offset[0] = 1'b0;
                end
                default: begin
                    req_size    = SIZE_WORD;
                    offset[1:0] = 2'd0;
                end
            endcase
        end
        req_addr      = '0;
        req_addr[5:0] = offset;
    endtask

    // Hold the request until req_ready is seen, then drop valid
    task automatic send_request();
        int waited;
        waited = 0;
        pick_request();
        req_valid = 1'b1;
        while (req_ready !== 1'b1 && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (req_ready !== 1'b1) begin
            $display("timeout at %0t: req_ready stayed low for %0d cycles", $time, TIMEOUT);
            timeouts++;
            hung = 1'b1;
        end else begin
            next_cycle();                   // Taken on the rising edge before
        end
        req_valid = 1'b0;
    endtask

    initial begin
        int          waited;
        logic [31:0] rnd;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_op       = OP_LOAD;
        req_size     = SIZE_WORD;
        req_unsigned = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        resp_ready   = 1'b0;
        repeat (4) @(negedge clk);          // Four rising edges in reset
        reset = 1'b0;
        next_cycle();
        for (int i = 0; i < NUM_REQ && !hung; i++) begin
            rnd = $random(seed);
            if (rnd[2:0] == 3'd0) begin
                next_cycle();               // Occasional idle gap
            end
            send_request();
        end
        waited = 0;
        while (pending != 0 && waited < TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (pending != 0) begin
            $display("timeout at %0t: last response never arrived", $time);
            timeouts++;
        end
        $display("requests %0d responses %0d errors %0d timeouts %0d",
                 req_count, resp_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0 && req_count == NUM_REQ && resp_count == NUM_REQ) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/dmem_checker.sv ====
`timescale 1ns/1ps

module dmem_checker #(
    parameter int ADDR_W = 15
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req_valid,
    input  logic                               req_ready,
    input  dmem_access_pkg::mem_op_e           req_op,
    input  dmem_access_pkg::access_size_e      req_size,
    input  logic                               req_unsigned,
    input  logic [ADDR_W-1:0]                  req_addr,
    input  logic [dmem_geom_pkg::DATA_W-1:0]   req_wdata,
    input  logic                               resp_valid,
    input  logic                               resp_ready,
    input  logic [dmem_geom_pkg::DATA_W-1:0]   resp_rdata,
    input  logic                               resp_error,
    output int                                 error_count,
    output int                                 req_count,
    output int                                 resp_count,
    output int                                 pending
);
    import dmem_geom_pkg::*;
    import dmem_access_pkg::*;

    localparam int MEM_BYTES = 2 ** ADDR_W;

    logic [BYTE_W-1:0] model [MEM_BYTES] = '{default: '0};   // Reference bytes zeroed at power-up
    logic [DATA_W-1:0] exp_data_q [$];    // Expected rdata per request
    logic              exp_err_q [$];     // Expected error flag
    int                exp_lat_q [$];     // Cycles from accept to resp_valid
    int                accept_q [$];      // Cycle number of the accepting edge
    int                errors = 0;
    int                requests = 0;
    int                responses = 0;
    int                outstanding = 0;
    int                cycle = 0;         // Rising edges seen
    logic              after_reset = 1'b0;
    logic              prev_valid = 1'b0;
    logic              held = 1'b0;       // Response stalled last edge
    logic [DATA_W-1:0] held_data = '0;
    logic              held_err = 1'b0;

    assign error_count = errors;
    assign req_count   = requests;
    assign resp_count  = responses;
    assign pending     = outstanding;

    // Bytes moved by one access
    function automatic int size_bytes(access_size_e size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    // Refuses odd halfwords, unaligned words and size 3
    function automatic logic refused(access_size_e size, logic [ADDR_W-1:0] addr);
        case (size)
            SIZE_BYTE: return 1'b0;
            SIZE_HALF: return addr[0];
            SIZE_WORD: return addr[1] | addr[0];
            default:   return 1'b1;
        endcase
    endfunction

    // Expected response and model update for the request taken on this edge
    task automatic accept_request();
        int                n;
        logic              bad;
        logic [DATA_W-1:0] value;
        logic [ADDR_W-1:0] idx;
        n     = size_bytes(req_size);
        bad   = refused(req_size, req_addr);
        value = '0;
        for (int i = 0; i < n; i++) begin
            idx = req_addr + ADDR_W'(i);                       // Little endian
            if (bad) begin
                value = '0;                                    // Memory left alone
            end else if (req_op == OP_STORE) begin
                model[idx] = req_wdata[BYTE_W*i +: BYTE_W];
            end else begin
                value[BYTE_W*i +: BYTE_W] = model[idx];
            end
        end
        if (!bad && req_op == OP_LOAD && !req_unsigned && value[BYTE_W*n-1]) begin
            for (int j = BYTE_W * n; j < DATA_W; j++) begin
                value[j] = 1'b1;                               // Sign fill
            end
        end
        exp_data_q.push_back(value);
        exp_err_q.push_back(bad);
        exp_lat_q.push_back(bad ? 1 : ((req_op == OP_STORE) ? 2 : 3));
        accept_q.push_back(cycle);
        requests++;
    endtask

    // resp_valid just rose
    task automatic check_latency();
        if (accept_q.size() == 0) begin
            $display("resp_valid rose at %0t with no request outstanding", $time);
            errors++;
        end else if (cycle - accept_q[0] != exp_lat_q[0]) begin
            $display("mismatch at %0t: latency %0d, expected %0d", $time,
                     cycle - accept_q[0], exp_lat_q[0]);
            errors++;
        end
    endtask

    // Response taken on this edge
    task automatic check_response();
        logic [DATA_W-1:0] exp_data;
        logic              exp_err;
        int                acc;
        responses++;
        if (exp_data_q.size() == 0) begin
            $display("response taken at %0t with no request outstanding", $time);
            errors++;
        end else begin
            exp_data = exp_data_q.pop_front();
            exp_err  = exp_err_q.pop_front();
            void'(exp_lat_q.pop_front());                      // Latency checked at the rise
            acc      = accept_q.pop_front();
            if (resp_error !== exp_err || resp_rdata !== exp_data) begin
                $display("mismatch at %0t: rdata %h error %b, expected %h error %b, cycle %0d",
                         $time, resp_rdata, resp_error, exp_data, exp_err, acc);
                errors++;
            end
        end
    endtask

    always @(posedge clk) begin
        cycle++;
        if (reset) begin
            after_reset = 1'b1;
            held        = 1'b0;
            prev_valid  = 1'b0;
        end else begin
            if (after_reset && (req_ready !== 1'b1 || resp_valid !== 1'b0)) begin
                $display("mismatch at %0t: after reset req_ready %b resp_valid %b, expected 1 0",
                         $time, req_ready, resp_valid);
                errors++;
            end
            after_reset = 1'b0;
            if (held && resp_valid !== 1'b1) begin
                $display("resp_valid dropped at %0t before the response was taken", $time);
                errors++;
            end else if (held && (resp_rdata !== held_data || resp_error !== held_err)) begin
                $display("mismatch at %0t: response changed under back-pressure", $time);
                errors++;
            end
            if (req_ready && accept_q.size() != 0) begin
                $display("req_ready was high at %0t while a request was outstanding", $time);
                errors++;
            end
            if (resp_valid && !prev_valid) begin
                check_latency();
            end
            if (resp_valid && resp_ready) begin
                check_response();
            end
            held      = resp_valid && !resp_ready;    // Must hold until taken
            held_data = resp_rdata;
            held_err  = resp_error;
            if (req_valid && req_ready) begin
                accept_request();
            end
            prev_valid = resp_valid;
        end
        outstanding = accept_q.size();
    end

endmodule

// ==== design/dmem_top.sv ====
`timescale 1ns/1ps

module dmem_top #(
    parameter int ADDR_W = 15
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req_valid,
    output logic                               req_ready,
    input  dmem_access_pkg::mem_op_e           req_op,
    input  dmem_access_pkg::access_size_e      req_size,
    input  logic                               req_unsigned,
    input  logic [ADDR_W-1:0]                  req_addr,
    input  logic [dmem_geom_pkg::DATA_W-1:0]   req_wdata,
    output logic                               resp_valid,
    input  logic                               resp_ready,
    output logic [dmem_geom_pkg::DATA_W-1:0]   resp_rdata,
    output logic                               resp_error
);
    import dmem_geom_pkg::*;
    import dmem_access_pkg::*;

    logic              access_strobe;    // Bank cycle
    logic              access_store;     // Registered op is a store
    access_size_e      acc_size;
    logic              acc_unsigned;
    logic [ADDR_W-1:0] acc_addr;
    logic [DATA_W-1:0] acc_wdata;
    logic              capture;          // Aligner load
    logic [ADDR_W-3:0] word_addr;        // Shared by all banks
    logic [LANE_W-1:0] lane;             // Byte offset in the word
    logic [BANKS-1:0]  bank_en;
    logic [BANKS-1:0]  bank_we;
    logic [DATA_W-1:0] bank_wdata;       // Lane 0 in the low byte
    logic [DATA_W-1:0] bank_rdata;
    logic [DATA_W-1:0] align_rdata;

    assign word_addr = acc_addr[ADDR_W-1:LANE_W];
    assign lane      = acc_addr[LANE_W-1:0];

    dmem_controller #(
        .ADDR_W (ADDR_W)
    ) dmem_controller_i (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_op        (req_op),
        .req_size      (req_size),
        .req_unsigned  (req_unsigned),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp_error    (resp_error),
        .access_strobe (access_strobe),
        .access_store  (access_store),
        .acc_size      (acc_size),
        .acc_unsigned  (acc_unsigned),
        .acc_addr      (acc_addr),
        .acc_wdata     (acc_wdata),
        .capture       (capture)
    );

    lane_steer lane_steer_i (
        .access_strobe (access_strobe),
        .access_store  (access_store),
        .acc_size      (acc_size),
        .lane          (lane),
        .acc_wdata     (acc_wdata),
        .bank_en       (bank_en),
        .bank_we       (bank_we),
        .bank_wdata    (bank_wdata)
    );

    // Byte lanes with bank_0 holding the lowest address of each word
    dmem_bank #(.ADDR_W(ADDR_W)) bank_0 (
        .clk   (clk),
        .en    (bank_en[0]),
        .we    (bank_we[0]),
        .addr  (word_addr),
        .wdata (bank_wdata[BYTE_W-1:0]),
        .rdata (bank_rdata[BYTE_W-1:0])
    );

    dmem_bank #(.ADDR_W(ADDR_W)) bank_1 (
        .clk   (clk),
        .en    (bank_en[1]),
        .we    (bank_we[1]),
        .addr  (word_addr),
        .wdata (bank_wdata[2*BYTE_W-1:BYTE_W]),
        .rdata (bank_rdata[2*BYTE_W-1:BYTE_W])
    );

    dmem_bank #(.ADDR_W(ADDR_W)) bank_2 (
        .clk   (clk),
        .en    (bank_en[2]),
        .we    (bank_we[2]),
        .addr  (word_addr),
        .wdata (bank_wdata[3*BYTE_W-1:2*BYTE_W]),
        .rdata (bank_rdata[3*BYTE_W-1:2*BYTE_W])
    );

    dmem_bank #(.ADDR_W(ADDR_W)) bank_3 (
        .clk   (clk),
        .en    (bank_en[3]),
        .we    (bank_we[3]),
        .addr  (word_addr),
        .wdata (bank_wdata[4*BYTE_W-1:3*BYTE_W]),
        .rdata (bank_rdata[4*BYTE_W-1:3*BYTE_W])
    );

    load_align load_align_i (
        .clk          (clk),
        .reset        (reset),
        .capture      (capture),
        .acc_size     (acc_size),
        .acc_unsigned (acc_unsigned),
        .lane         (lane),
        .bank_rdata   (bank_rdata),
        .rdata        (align_rdata)
    );

    // Stores and refused requests answer with zero data
    assign resp_rdata = (resp_error || access_store) ? '0 : align_rdata;

endmodule

// ==== design/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               capture,
    input  dmem_access_pkg::access_size_e      acc_size,
    input  logic                               acc_unsigned,
    input  logic [dmem_geom_pkg::LANE_W-1:0]   lane,
    input  logic [dmem_geom_pkg::DATA_W-1:0]   bank_rdata,
    output logic [dmem_geom_pkg::DATA_W-1:0]   rdata
);
    import dmem_geom_pkg::*;
    import dmem_access_pkg::*;

    logic [BYTE_W-1:0] byte_sel;     // Addressed byte
    logic [HALF_W-1:0] half_sel;     // Addressed halfword
    logic              byte_fill;    // Extension bit for byte loads
    logic              half_fill;    // Extension bit for halfword loads
    logic [DATA_W-1:0] load_ext;     // Extended result before the register

    assign byte_sel = bank_rdata[lane*BYTE_W +: BYTE_W];
    assign half_sel = lane[1] ? bank_rdata[DATA_W-1:HALF_W] : bank_rdata[HALF_W-1:0];

    // Sign bit unless zero extension asked for
    assign byte_fill = ~acc_unsigned & byte_sel[BYTE_W-1];
    assign half_fill = ~acc_unsigned & half_sel[HALF_W-1];

    always_comb begin
        case (acc_size)
            SIZE_BYTE: load_ext = {{(DATA_W-BYTE_W){byte_fill}}, byte_sel};
            SIZE_HALF: load_ext = {{(DATA_W-HALF_W){half_fill}}, half_sel};
            SIZE_WORD: load_ext = bank_rdata;       // Lanes already in order
            default:   load_ext = '0;               // Illegal size clears the result
        endcase
    end

    // Result register loaded once per load in CAPTURE
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= '0;
        end else if (capture) begin
            rdata <= load_ext;
        end
    end

endmodule

// ==== design/lane_steer.sv ====
`timescale 1ns/1ps

module lane_steer (
    input  logic                                  access_strobe,
    input  logic                                  access_store,
    input  dmem_access_pkg::access_size_e         acc_size,
    input  logic [dmem_geom_pkg::LANE_W-1:0]      lane,
    input  logic [dmem_geom_pkg::DATA_W-1:0]      acc_wdata,
    output logic [dmem_geom_pkg::BANKS-1:0]       bank_en,
    output logic [dmem_geom_pkg::BANKS-1:0]       bank_we,
    output logic [dmem_geom_pkg::DATA_W-1:0]      bank_wdata
);
    import dmem_geom_pkg::*;
    import dmem_access_pkg::*;

    logic [BANKS-1:0] lane_mask;    // Lanes touched by this size and address

    // Lane selection
    always_comb begin
        case (acc_size)
            SIZE_BYTE: lane_mask = {{(BANKS-1){1'b0}}, 1'b1} << lane;   // Single lane
            SIZE_HALF: lane_mask = lane[1] ? 4'b1100 : 4'b0011;         // Upper or lower pair
            SIZE_WORD: lane_mask = {BANKS{1'b1}};                       // All four
            default:   lane_mask = '0;                                  // Never reaches ACCESS
        endcase
    end

    assign bank_en = lane_mask & {BANKS{access_strobe}};    // Only in the access cycle
    assign bank_we = bank_en & {BANKS{access_store}};       // Writes only for stores

    // Write data replicated so every enabled lane sees its byte
    always_comb begin
        case (acc_size)
            SIZE_BYTE: bank_wdata = {BANKS{acc_wdata[BYTE_W-1:0]}};     // Low byte everywhere
            SIZE_HALF: bank_wdata = {2{acc_wdata[HALF_W-1:0]}};         // Low half in both halves
            SIZE_WORD: bank_wdata = acc_wdata;                          // Straight through
            default:   bank_wdata = '0;
        endcase
    end

endmodule

// ==== design/dmem_controller.sv ====
`timescale 1ns/1ps

module dmem_controller #(
    parameter int ADDR_W = 15
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req_valid,
    output logic                               req_ready,
    input  dmem_access_pkg::mem_op_e           req_op,
    input  dmem_access_pkg::access_size_e      req_size,
    input  logic                               req_unsigned,
    input  logic [ADDR_W-1:0]                  req_addr,
    input  logic [dmem_geom_pkg::DATA_W-1:0]   req_wdata,
    output logic                               resp_valid,
    input  logic                               resp_ready,
    output logic                               resp_error,
    output logic                               access_strobe,
    output logic                               access_store,
    output dmem_access_pkg::access_size_e      acc_size,
    output logic                               acc_unsigned,
    output logic [ADDR_W-1:0]                  acc_addr,
    output logic [dmem_geom_pkg::DATA_W-1:0]   acc_wdata,
    output logic                               capture
);
    import dmem_access_pkg::*;

    typedef enum logic [1:0] {
        IDLE,       // Waiting for a request
        ACCESS,     // Single bank cycle
        CAPTURE,    // Load data into the aligner
        RESP        // Holding the response
    } state_e;

    state_e  state;
    mem_op_e acc_op;        // Registered op
    logic    misaligned;    // Check on the incoming request

    // The only alignment check in the design
    always_comb begin
        case (req_size)
            SIZE_BYTE: misaligned = 1'b0;                  // Any address is fine
            SIZE_HALF: misaligned = req_addr[0];           // Must be even
            SIZE_WORD: misaligned = |req_addr[1:0];        // Must be word aligned
            default:   misaligned = 1'b1;                  // Size 3 is refused
        endcase
    end

    // Control state
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            resp_error <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_valid) begin
                        resp_error <= misaligned;            // Error skips the banks
                        state      <= misaligned ? RESP : ACCESS;
                    end
                end
                ACCESS: begin
                    state <= (acc_op == OP_STORE) ? RESP : CAPTURE;  // Store is done here
                end
                CAPTURE: begin
                    state <= RESP;                             // Aligner loads this edge
                end
                RESP: begin
                    if (resp_ready) begin
                        state <= IDLE;                         // Response taken
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Request register loaded on the accepting edge only
    always_ff @(posedge clk) begin
        if (state == IDLE && req_valid) begin
            acc_op       <= req_op;
            acc_size     <= req_size;
            acc_unsigned <= req_unsigned;
            acc_addr     <= req_addr;
            acc_wdata    <= req_wdata;
        end
    end

    assign req_ready     = (state == IDLE);       // One request in flight
    assign resp_valid    = (state == RESP);       // Held under back-pressure
    assign access_strobe = (state == ACCESS);     // Exactly one cycle per aligned request
    assign capture       = (state == CAPTURE);    // Loads only
    assign access_store  = (acc_op == OP_STORE);

endmodule

// ==== dmem_bank/dmem_bank.sv ====
`timescale 1ns/1ps

module dmem_bank #(
    parameter int ADDR_W = 15
) (
    input  logic                               clk,
    input  logic                               en,
    input  logic                               we,
    input  logic [ADDR_W-3:0]                  addr,
    input  logic [dmem_geom_pkg::BYTE_W-1:0]   wdata,
    output logic [dmem_geom_pkg::BYTE_W-1:0]   rdata
);
    import dmem_geom_pkg::*;

    localparam int DEPTH = 2 ** (ADDR_W - 2);   // One byte per word address

    // Power-up contents are zero as in an initialized FPGA RAM
    logic [BYTE_W-1:0] mem [DEPTH] = '{default: '0};

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;     // Store
            end else begin
                rdata <= mem[addr];     // Read into output register
            end
        end
        // Output register holds when not reading
    end

endmodule

// ==== common/dmem_access_pkg.sv ====
package dmem_access_pkg;

    // Access size as the processor encodes it
    // Encoding 3 is left unnamed and is refused as misaligned
    typedef enum logic [1:0] {
        SIZE_WORD = 2'd0,   // 32-bit access
        SIZE_BYTE = 2'd1,   // 8-bit access
        SIZE_HALF = 2'd2    // 16-bit access
    } access_size_e;

    // Direction of a request
    typedef enum logic {
        OP_LOAD  = 1'b0,    // Read returning data
        OP_STORE = 1'b1     // Write returning zero data
    } mem_op_e;

endpackage

// ==== common/dmem_geom_pkg.sv ====
package dmem_geom_pkg;

    // Datapath shape of the byte-banked memory

    parameter int DATA_W = 32;               // Processor word
    parameter int BYTE_W = 8;                // One bank is one byte wide
    parameter int BANKS  = DATA_W / BYTE_W;  // Four byte lanes
    parameter int LANE_W = $clog2(BANKS);    // Low address bits picking a lane

    // Halfword width, used by the load extension logic
    parameter int HALF_W = 2 * BYTE_W;

endpackage
